// File: design/card_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the test card bank on the 16-bit I/O backplane
// Bus request, per-card select and per-card response structs
// Register offsets inside each four-address card window
// Modules refer to these by scoped names such as card_pkg::card_sel_t
//////////////////////////////////////////////////////////////////////

`default_nettype none

package card_pkg;

   localparam int DATA_W = 16;                  // Backplane data bus
   localparam int ADDR_W = 24;                  // Backplane address bus

   // Register map within one card
   localparam logic [1:0] REG_PORT_A  = 2'd0;   // Operand A
   localparam logic [1:0] REG_PORT_B  = 2'd1;   // Operand B
   localparam logic [1:0] REG_PRODUCT = 2'd2;   // Low half of A*B, read only
   localparam logic [1:0] REG_TIMER   = 2'd3;   // Countdown and interrupt

   typedef struct packed {
      logic              strobe;                // One-cycle request strobe
      logic              io;                    // I/O space when set
      logic              write;                 // Write when set
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;                  // Write data
   } bus_req_t;

   typedef struct packed {
      logic              strobe;                // Access inside the window
      logic              write;
      logic [1:0]        offset;                // Register within the card
      logic [DATA_W-1:0] data;
   } card_sel_t;

   typedef struct packed {
      logic              rd_valid;              // One-cycle read strobe
      logic [DATA_W-1:0] rd_data;
      logic              irq;                   // Level
   } card_rsp_t;

   // Width of a card index, never below one bit
   function automatic int idx_w(input int n);
      return (n > 1) ? $clog2(n) : 1;
   endfunction

endpackage

`default_nettype wire

// File: design/io_decoder.sv
//////////////////////////////////////////////////////////////////////
// Address decoder for the card window
// Registers each bus request once and turns I/O cycles that fall in
// CARD_BASE .. CARD_BASE+4*N_CARDS-1 into a card select plus a
// one-hot hit vector. Memory cycles and other I/O give no hit.
// Latency from req to sel and hit is one cycle.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_decoder #(
   parameter int                          N_CARDS   = 4,
   parameter logic [card_pkg::ADDR_W-1:0] CARD_BASE = 24'h3F0
) (
   input  wire logic               nr,                // Bus clock
   input  wire logic               reset,             // Sync, active high
   input  wire card_pkg::bus_req_t req,               // Incoming bus cycle
   output card_pkg::card_sel_t     sel,               // Same copy to all cards
   output logic [N_CARDS-1:0]      hit                // One-hot card select
);

   typedef logic [card_pkg::ADDR_W-1:0] addr_t;

   localparam addr_t WIN_SIZE = addr_t'(4 * N_CARDS); // Four registers per card

   addr_t              diff;                          // Offset from card 0
   logic               in_window;                     // Valid I/O hit
   logic [N_CARDS-1:0] hit_d;                         // Next hit vector

   //////////////////////////////////////////////////////////////////////
   // Window compare
   //////////////////////////////////////////////////////////////////////

   // Addresses below the base wrap to a large offset and miss the window
   assign diff      = req.addr - CARD_BASE;
   assign in_window = req.strobe & req.io & (diff < WIN_SIZE);

   always_comb begin
      for (int k = 0; k < N_CARDS; k++) begin
         hit_d[k] = in_window && ((diff >> 2) == addr_t'(k)); // Card k slot
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Select register
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nr) begin
      sel.write  <= req.write;                        // Payload
      sel.offset <= diff[1:0];                        // Register within card
      sel.data   <= req.data;
      if (reset) begin
         sel.strobe <= 1'b0;
         hit        <= '0;
      end else begin
         sel.strobe <= in_window;                     // Only window accesses
         hit        <= hit_d;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Never more than one card addressed at once
   a_hit_onehot0 : assert property (@(posedge nr) disable iff (reset)
      $onehot0(hit))
      else $error("io_decoder: hit vector not one-hot");

endmodule

`default_nettype wire

// File: design/test_card.sv
//////////////////////////////////////////////////////////////////////
// One test card on the I/O backplane
// Two operand ports, a product readback and a countdown timer that
// raises a level interrupt when it expires. Acts only when the
// decoder strobe and this card's hit bit are both set. Reads answer
// one cycle after the select, writes land at the end of the select.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module test_card (
   input  wire logic                nr,               // Bus clock
   input  wire logic                reset,            // Sync, active high
   input  wire card_pkg::card_sel_t sel,              // Decoded access
   input  wire logic                hit,              // This card addressed
   output card_pkg::card_rsp_t      rsp               // Read data and irq
);

   logic [card_pkg::DATA_W-1:0] port_a;               // Operand A
   logic [card_pkg::DATA_W-1:0] port_b;               // Operand B
   logic [card_pkg::DATA_W-1:0] product;              // Low half of A*B
   logic [card_pkg::DATA_W-1:0] count;                // Timer count
   logic                        armed;                // Timer running or expired
   logic                        irq;

   logic                        access;               // Strobe for this card
   logic                        wr_access;
   logic                        rd_access;
   logic                        timer_wr;             // Write to REG_TIMER

   logic                        rd_valid_q;
   logic [card_pkg::DATA_W-1:0] rd_data_q;

   assign access    = sel.strobe & hit;
   assign wr_access = access & sel.write;
   assign rd_access = access & ~sel.write;
   assign timer_wr  = wr_access & (sel.offset == card_pkg::REG_TIMER);

   assign product = port_a * port_b;                  // Truncated to 16 bits

   //////////////////////////////////////////////////////////////////////
   // Operand ports
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nr) begin
      if (reset) begin
         port_a <= '0;
         port_b <= '0;
      end else if (wr_access) begin
         case (sel.offset)
            card_pkg::REG_PORT_A: port_a <= sel.data;
            card_pkg::REG_PORT_B: port_b <= sel.data;
            default: ;                                // Product is read only
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Countdown timer
   //////////////////////////////////////////////////////////////////////

   // A new write always wins over the running count
   always_ff @(posedge nr) begin
      if (reset) begin
         count <= '0;
         armed <= 1'b0;
      end else if (timer_wr) begin
         count <= sel.data;                           // Load new period
         armed <= |sel.data;                          // Zero disarms
      end else if (armed && (count != '0)) begin
         count <= count - 1'b1;                       // One per cycle
      end
   end

   assign irq = armed & (count == '0);                // Held until rewritten

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge nr) begin
      if (reset) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_access;                     // One cycle later
      end
   end

   always_ff @(posedge nr) begin
      if (rd_access) begin
         case (sel.offset)
            card_pkg::REG_PORT_A:  rd_data_q <= port_a;
            card_pkg::REG_PORT_B:  rd_data_q <= port_b;
            card_pkg::REG_PRODUCT: rd_data_q <= product;
            default:               rd_data_q <= count;  // REG_TIMER
         endcase
      end
   end

   assign rsp = '{
      rd_valid: rd_valid_q,
      rd_data:  rd_data_q,
      irq:      irq
   };

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Once raised the interrupt holds with an empty count until rewritten
   a_irq_sticky : assert property (@(posedge nr) disable iff (reset)
      irq && !timer_wr |=> irq && (count == '0))
      else $error("test_card: interrupt dropped without a timer write");

endmodule

`default_nettype wire

// File: design/io_response_merge.sv
//////////////////////////////////////////////////////////////////////
// Response merge for the card bank
// Purely combinational. ORs read data from the cards that flag
// rd_valid into one response, ORs the interrupts into one level and
// picks the lowest-numbered pending card as irq_card.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module io_response_merge #(
   parameter int N_CARDS = 4
) (
   input  wire card_pkg::card_rsp_t                card_rsp [N_CARDS], // Per card
   output card_pkg::card_rsp_t                     rsp,                // Merged
   output logic [card_pkg::idx_w(N_CARDS)-1:0]     irq_card            // Lowest pending
);

   localparam int IDX_W = card_pkg::idx_w(N_CARDS);

   logic [N_CARDS-1:0] rd_valid_vec;                  // Responders this cycle

   //////////////////////////////////////////////////////////////////////
   // Merge and priority pick
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      rsp      = '0;
      irq_card = '0;
      // Walk downward so the lowest pending card is the last to win
      for (int k = N_CARDS - 1; k >= 0; k--) begin
         rd_valid_vec[k] = card_rsp[k].rd_valid;
         if (card_rsp[k].rd_valid) begin
            rsp.rd_valid = 1'b1;
            rsp.rd_data  = rsp.rd_data | card_rsp[k].rd_data;
         end
         if (card_rsp[k].irq) begin
            rsp.irq  = 1'b1;
            irq_card = IDX_W'(k);                     // Overwritten by lower cards
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   // Two readers would corrupt the OR. Deferred to skip settle glitches
   always_comb begin
      a_one_reader : assert final ($onehot0(rd_valid_vec))
         else $error("io_response_merge: more than one card answered a read");
   end

endmodule

`default_nettype wire

// File: design/card_bank_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the test card bank
// One decoder feeds N_CARDS identical cards, whose responses are
// merged into a single read response and interrupt. A read strobe
// in cycle t returns rsp.rd_valid in cycle t+2. irq_card names the
// lowest-numbered card with a pending interrupt.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module card_bank_top #(
   parameter int                          N_CARDS   = 4,      // Cards on the bus
   parameter logic [card_pkg::ADDR_W-1:0] CARD_BASE = 24'h3F0 // I/O address of card 0
) (
   input  wire logic                           nr,            // Bus clock
   input  wire logic                           reset,         // Sync, active high
   input  wire card_pkg::bus_req_t             req,           // One request per strobe
   output card_pkg::card_rsp_t                 rsp,           // Read data and irq
   output logic [card_pkg::idx_w(N_CARDS)-1:0] irq_card       // Valid while rsp.irq
);

   card_pkg::card_sel_t sel;                          // Broadcast select
   logic [N_CARDS-1:0]  hit;                          // One-hot card index
   card_pkg::card_rsp_t card_rsp [N_CARDS];           // Per-card responses

   //////////////////////////////////////////////////////////////////////
   // Decode, cards, merge
   //////////////////////////////////////////////////////////////////////

   io_decoder #(
      .N_CARDS   (N_CARDS),
      .CARD_BASE (CARD_BASE)
   ) u_decoder (
      .nr    (nr),
      .reset (reset),
      .req   (req),
      .sel   (sel),
      .hit   (hit)
   );

   for (genvar k = 0; k < N_CARDS; k++) begin : g_card
      test_card u_card (
         .nr    (nr),
         .reset (reset),
         .sel   (sel),
         .hit   (hit[k]),                             // Own slot only
         .rsp   (card_rsp[k])
      );
   end

   io_response_merge #(
      .N_CARDS (N_CARDS)
   ) u_merge (
      .card_rsp (card_rsp),
      .rsp      (rsp),
      .irq_card (irq_card)
   );

endmodule

`default_nettype wire

// File: tb/tb_card_bank_table.svh
//////////////////////////////////////////////////////////////////////
// Stimulus and expected-value table for the card bank testbench
// Each row is one bus cycle (or one irq sample) followed by idle
// cycles. Included inside the testbench module, filled by load_table
//////////////////////////////////////////////////////////////////////

`ifndef TB_CARD_BANK_TABLE_SVH
`define TB_CARD_BANK_TABLE_SVH

localparam int OP_WR      = 0;                        // Write, any space
localparam int OP_RD      = 1;                        // Read, answer expected
localparam int OP_RD_NONE = 2;                        // Read, must stay silent
localparam int OP_IRQ     = 3;                        // No request, sample irq

localparam int SRC_TABLE  = 0;                        // Use row data and exp
localparam int SRC_RAND_A = 1;                        // Random operand A
localparam int SRC_RAND_B = 2;                        // Random operand B
localparam int SRC_RAND_P = 3;                        // Product of the two

typedef struct {
   string       name;
   int          kind;
   logic        io;
   logic        wr;
   logic [23:0] addr;
   logic [15:0] data;
   int          idle;                                 // Quiet cycles after
   logic [15:0] exp;                                  // Read data or {irq_card, irq}
   int          src;
} row_t;

row_t rows[$];

function automatic void add_row(input string name, input int kind, input logic io,
                                input logic wr, input logic [23:0] addr,
                                input logic [15:0] data, input int idle,
                                input logic [15:0] exp, input int src);
   row_t r;
   r = '{name, kind, io, wr, addr, data, idle, exp, src};
   rows.push_back(r);
endfunction

// Card k at 0x3F0 + 4k, offsets A, B, product, timer
function automatic void load_table();
   logic [15:0] op_a [4];
   logic [15:0] op_b [4];
   for (int a = 0; a < 16; a++) begin                 // Every register after reset
      add_row($sformatf("reset_rd_%0h", 24'h3F0 + a), OP_RD, 1, 0, 24'h3F0 + 24'(a),
              0, 0, 0, SRC_TABLE);
   end
   add_row("reset_irq", OP_IRQ, 0, 0, 0, 0, 0, 16'h0000, SRC_TABLE);
   for (int k = 0; k < 4; k++) begin
      op_a[k] = 16'hA000 | 16'(k * 16'h0101);
      op_b[k] = 16'h0050 + 16'(k * 3);
      add_row($sformatf("wr_a_%0d", k), OP_WR, 1, 1, 24'h3F0 + 24'(4 * k), op_a[k], 0, 0,
              SRC_TABLE);
      add_row($sformatf("wr_b_%0d", k), OP_WR, 1, 1, 24'h3F1 + 24'(4 * k), op_b[k], 0, 0,
              SRC_TABLE);
      add_row($sformatf("rd_a_%0d", k), OP_RD, 1, 0, 24'h3F0 + 24'(4 * k), 0, 0, op_a[k],
              SRC_TABLE);
      add_row($sformatf("rd_b_%0d", k), OP_RD, 1, 0, 24'h3F1 + 24'(4 * k), 0, 1, op_b[k],
              SRC_TABLE);
   end
   for (int k = 0; k < 4; k++) begin                  // Back to back, one per card
      add_row($sformatf("rd_prod_%0d", k), OP_RD, 1, 0, 24'h3F2 + 24'(4 * k), 0, 0,
              16'(op_a[k] * op_b[k]), SRC_TABLE);
   end
   add_row("wr_a_rand", OP_WR, 1, 1, 24'h3F8, 0, 0, 0, SRC_RAND_A);
   add_row("wr_b_rand", OP_WR, 1, 1, 24'h3F9, 0, 0, 0, SRC_RAND_B);
   add_row("rd_prod_rand", OP_RD, 1, 0, 24'h3FA, 0, 0, 0, SRC_RAND_P);
   add_row("rd_a_rand", OP_RD, 1, 0, 24'h3F8, 0, 1, 0, SRC_RAND_A);
   // Cycles that must not reach a card
   add_row("mem_wr", OP_WR, 0, 1, 24'h3F0, 16'hFFFF, 0, 0, SRC_TABLE);
   add_row("io_wr_below", OP_WR, 1, 1, 24'h3EF, 16'hFFFF, 0, 0, SRC_TABLE);
   add_row("io_wr_above", OP_WR, 1, 1, 24'h400, 16'hFFFF, 0, 0, SRC_TABLE);
   add_row("mem_rd", OP_RD_NONE, 0, 0, 24'h3F0, 0, 0, 0, SRC_TABLE);
   add_row("io_rd_above", OP_RD_NONE, 1, 0, 24'h400, 0, 0, 0, SRC_TABLE);
   add_row("rd_tmr3_kept", OP_RD, 1, 0, 24'h3FF, 0, 0, 16'h0000, SRC_TABLE); // Still idle
   add_row("rd_a_0_kept", OP_RD, 1, 0, 24'h3F0, 0, 2, op_a[0], SRC_TABLE);
   // Timer of card 1 with N = 5, irq lands at t+N+2
   add_row("tmr1_wr", OP_WR, 1, 1, 24'h3F7, 16'd5, 0, 0, SRC_TABLE);
   add_row("tmr1_rd", OP_RD, 1, 0, 24'h3F7, 0, 4, 16'd5, SRC_TABLE);
   add_row("tmr1_irq_early", OP_IRQ, 0, 0, 0, 0, 0, 16'h0000, SRC_TABLE);
   add_row("tmr1_irq", OP_IRQ, 0, 0, 0, 0, 0, 16'h0003, SRC_TABLE);
   add_row("tmr1_clr", OP_WR, 1, 1, 24'h3F7, 16'd0, 1, 0, SRC_TABLE);
   add_row("tmr1_irq_clr", OP_IRQ, 0, 0, 0, 0, 0, 16'h0000, SRC_TABLE);
   // Cards 2 and 3 both expired
   add_row("tmr3_wr", OP_WR, 1, 1, 24'h3FF, 16'd2, 0, 0, SRC_TABLE);
   add_row("tmr2_wr", OP_WR, 1, 1, 24'h3FB, 16'd3, 6, 0, SRC_TABLE);
   add_row("prio_card2", OP_IRQ, 0, 0, 0, 0, 0, 16'h0005, SRC_TABLE);
   add_row("tmr2_clr", OP_WR, 1, 1, 24'h3FB, 16'd0, 1, 0, SRC_TABLE);
   add_row("prio_card3", OP_IRQ, 0, 0, 0, 0, 0, 16'h0007, SRC_TABLE);
   add_row("tmr3_clr", OP_WR, 1, 1, 24'h3FF, 16'd0, 1, 0, SRC_TABLE);
   add_row("prio_none", OP_IRQ, 0, 0, 0, 0, 0, 16'h0000, SRC_TABLE);
endfunction

`endif

// File: tb/tb_card_bank.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the test card bank
// Applies the table rows one by one, checks read responses two
// cycles after each read strobe and samples irq where a row asks.
// Run through the file list with any open-source simulator
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_card_bank;

   `include "tb_card_bank_table.svh"

   typedef struct {
      string       name;
      int          due;                               // Cycle of rd_valid
      logic [15:0] exp;
   } pend_t;

   logic                nr;
   logic                reset;
   card_pkg::bus_req_t  req;
   card_pkg::card_rsp_t rsp;
   logic [1:0]          irq_card;

   pend_t       pend[$];                              // Reads in flight
   pend_t       head;
   int          cyc;                                  // Cycle counter
   int          limit;                                // Timeout in cycles
   int          errors;
   int          checks;
   logic        monitor_on;
   logic [15:0] rand_a;
   logic [15:0] rand_b;

   card_bank_top u_dut (
      .nr       (nr),
      .reset    (reset),
      .req      (req),
      .rsp      (rsp),
      .irq_card (irq_card)
   );

   initial begin
      nr = 1'b0;
      forever #50 nr = ~nr;                           // 100 ns period
   end

   //////////////////////////////////////////////////////////////////////
   // Checking
   //////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // Mid-cycle sample of the read response
   always @(negedge nr) begin
      if (monitor_on) begin
         if (rsp.rd_valid) begin
            if (pend.size() == 0) begin
               errors++;
               $display("ERROR: read data in cycle %0d with no read outstanding", cyc);
            end else begin
               head = pend.pop_front();
               if (head.due != cyc) begin
                  errors++;
                  $display("ERROR: %s answered in cycle %0d instead of %0d",
                           head.name, cyc, head.due);
               end
               check_value(head.name, head.exp, rsp.rd_data);
            end
         end else if (pend.size() != 0 && pend[0].due <= cyc) begin
            head = pend.pop_front();
            errors++;
            $display("ERROR: %s got no read response in cycle %0d", head.name, head.due);
         end
      end
   end

   always @(posedge nr) begin
      cyc <= cyc + 1;
      if (cyc >= limit) begin
         $display("ERROR: timeout, run passed its limit of %0d cycles", limit);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic apply_row(input row_t r);
      logic [15:0] data;
      logic [15:0] exp;
      pend_t       p;
      data = r.data;
      exp  = r.exp;
      case (r.src)
         SRC_RAND_A: begin
            data = rand_a;
            exp  = rand_a;
         end
         SRC_RAND_B: data = rand_b;
         SRC_RAND_P: exp = 16'(rand_a * rand_b);     // Low half only
         default: ;
      endcase
      @(posedge nr);
      #5;
      if (r.kind == OP_IRQ) begin
         req.strobe = 1'b0;
         @(negedge nr);
         check_value(r.name, exp, {13'd0, irq_card, rsp.irq});
      end else begin
         req = '{strobe: 1'b1, io: r.io, write: r.wr, addr: r.addr, data: data};
         if (r.kind == OP_RD) begin
            p = '{r.name, cyc + 2, exp};              // Fixed two-cycle latency
            pend.push_back(p);
         end
      end
      repeat (r.idle) begin
         @(posedge nr);
         #5;
         req.strobe = 1'b0;
      end
   endtask

   initial begin
      req        = '0;
      reset      = 1'b1;
      cyc        = 0;
      limit      = 1000;                              // Until the table is known
      errors     = 0;
      checks     = 0;
      monitor_on = 1'b0;
      void'($urandom(46109));
      rand_a = 16'($urandom);
      rand_b = 16'($urandom);
      load_table();
      limit = 4 + 20;                                 // Reset plus margin
      foreach (rows[i]) begin
         limit += 1 + rows[i].idle;
      end

      repeat (4) @(posedge nr);
      #5;
      reset      = 1'b0;
      monitor_on = 1'b1;

      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      @(posedge nr);
      #5;
      req.strobe = 1'b0;
      repeat (4) @(posedge nr);                       // Drain reads in flight
      if (pend.size() != 0) begin
         errors++;
         $display("ERROR: %0d reads never answered", pend.size());
      end

      $display("Checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
+incdir+tb
design/card_pkg.sv
design/io_decoder.sv
design/test_card.sv
design/io_response_merge.sv
design/card_bank_top.sv
tb/tb_card_bank.sv

// File: Makefile
# Verilator build and run for the test card bank testbench

VERILATOR ?= verilator
TOP       ?= tb_card_bank
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= SIMULATION PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run, fail unless the pass message is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) design/*.sv tb/*.sv tb/*.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
